/* sata_link_pkg.sv */
// SATA link layer shared types: primitive dwords, primitive classes, link states, completion codes
`default_nettype none

package sata_link_pkg;

   localparam int WORD_W = 32;                    // One dword per clock

   typedef logic [WORD_W-1:0] prim_word_t;

   // Standard primitive encodings, sent and received with k set
   localparam prim_word_t P_ALIGN = 32'h7B4A_4ABC;
   localparam prim_word_t P_SYNC  = 32'hB5B5_957C;
   localparam prim_word_t P_X_RDY = 32'h5757_B57C;
   localparam prim_word_t P_R_RDY = 32'h4A4A_957C;
   localparam prim_word_t P_SOF   = 32'h3737_B57C;
   localparam prim_word_t P_EOF   = 32'hD5D5_B57C;
   localparam prim_word_t P_HOLD  = 32'hD5D5_AA7C;
   localparam prim_word_t P_HOLDA = 32'h9595_AA7C;
   localparam prim_word_t P_R_IP  = 32'h5555_B57C;
   localparam prim_word_t P_R_OK  = 32'h3535_B57C;
   localparam prim_word_t P_R_ERR = 32'h5656_B57C;
   localparam prim_word_t P_WTRM  = 32'h5858_B57C;

   typedef enum logic [3:0] {
      PRIM_ALIGN, PRIM_SYNC, PRIM_X_RDY, PRIM_R_RDY,
      PRIM_SOF, PRIM_EOF, PRIM_HOLD, PRIM_HOLDA,
      PRIM_R_IP, PRIM_R_OK, PRIM_R_ERR, PRIM_WTRM,
      PRIM_DATA,                                  // k flag clear
      PRIM_OTHER                                  // Unknown k dword
   } prim_class_t;

   typedef enum logic [4:0] {
      // Receive side
      S_IDLE, S_RCV_WAIT_FIFO, S_RCV_CHK_RDY, S_RCV_DATA, S_RCV_HOLD_TX,
      S_RCV_HOLD_ACK, S_RCV_EOF, S_GOOD_CRC, S_GOOD_END, S_BAD_END,
      // Transmit side
      S_SEND_CHK_RDY, S_SEND_SOF, S_SEND_DATA, S_SEND_HOLD_ACK, S_SEND_HOLD,
      S_SEND_CRC, S_SEND_EOF, S_SEND_WAIT, S_SYNC_ESCAPE,
      // Completion report, held until the command layer takes the word
      S_RPT_COLLIDE, S_RPT_TX_SYNC, S_RPT_R_OK, S_RPT_R_ERR,
      S_RPT_RX_SYNC, S_RPT_GOOD, S_RPT_BAD, S_RPT_ABORT
   } link_state_t;

   typedef enum logic [3:0] {
      CMPL_COLLIDE,
      CMPL_TX_SYNC,
      CMPL_R_OK,
      CMPL_R_ERR,
      CMPL_RX_SYNC,
      CMPL_GOOD,
      CMPL_BAD,
      CMPL_ABORT
   } cmpl_code_t;

endpackage

`default_nettype wire

/* prim_decoder.sv */
// Primitive decoder: classifies the incoming dword and reduces transmit FIFO flags
`timescale 1ns/1ps
`default_nettype none

module prim_decoder (
   input  var sata_link_pkg::prim_word_t  rx_char,
   input  wire                            rx_chark,
   input  wire                            fifo_sof,
   input  wire                            fifo_eof,
   input  wire                            fifo_empty,
   input  wire                            fifo_almost_empty,
   output sata_link_pkg::prim_class_t     rx_class,
   output logic                           fifo_data_ok,
   output logic                           fifo_end_ok,
   output logic                           fifo_start_ok
);

   import sata_link_pkg::*;

   logic fifo_low;

   assign fifo_low      = fifo_empty | fifo_almost_empty;
   assign fifo_data_ok  = ~fifo_low & ~fifo_eof;         // Room to keep streaming
   assign fifo_end_ok   = fifo_data_ok | (fifo_low & fifo_eof);
   assign fifo_start_ok = ~fifo_empty & fifo_sof;        // Frame waiting at the head

   always_comb
   begin
      if (!rx_chark)
         rx_class = PRIM_DATA;
      else
      begin
         case (rx_char)
            P_ALIGN: rx_class = PRIM_ALIGN;
            P_SYNC:  rx_class = PRIM_SYNC;
            P_X_RDY: rx_class = PRIM_X_RDY;
            P_R_RDY: rx_class = PRIM_R_RDY;
            P_SOF:   rx_class = PRIM_SOF;
            P_EOF:   rx_class = PRIM_EOF;
            P_HOLD:  rx_class = PRIM_HOLD;
            P_HOLDA: rx_class = PRIM_HOLDA;
            P_R_IP:  rx_class = PRIM_R_IP;
            P_R_OK:  rx_class = PRIM_R_OK;
            P_R_ERR: rx_class = PRIM_R_ERR;
            P_WTRM:  rx_class = PRIM_WTRM;
            default: rx_class = PRIM_OTHER;
         endcase
      end
   end

endmodule

`default_nettype wire

/* link_sequencer.sv */
// Link sequencer: state machine for transmit, receive, hold and collision, with receive strobes
`timescale 1ns/1ps
`default_nettype none

module link_sequencer (
   input  wire                          clk_75m,
   input  wire                          arst_n,
   input  wire                          link_up,
   input  var sata_link_pkg::prim_class_t rx_class,
   input  wire                          fifo_data_ok,
   input  wire                          fifo_end_ok,
   input  wire                          fifo_start_ok,
   input  wire                          tx_pop,
   input  wire                          crc_ok,
   input  wire                          crc_rdy,
   input  wire                          tx_abort,
   input  wire                          rcv_ready,
   input  wire                          rcv_abort,
   input  wire                          cmpl_ready,
   output sata_link_pkg::link_state_t   next_state,
   output logic                         rx_sof,
   output logic                         rx_eof,
   output logic                         rx_datav,
   output logic                         link_idle
);

   import sata_link_pkg::*;

   link_state_t state;
   logic        is_prim;
   logic        rcv_body;

   assign is_prim  = (rx_class != PRIM_DATA);
   assign rcv_body = (state == S_RCV_DATA) || (state == S_RCV_HOLD_TX) ||
                     (state == S_RCV_HOLD_ACK);

   always_ff @(posedge clk_75m or negedge arst_n)
   begin
      if (!arst_n)
         state <= S_IDLE;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = state;
      case (state)
         S_IDLE:
            if (fifo_start_ok)
               next_state = S_SEND_CHK_RDY;
            else if (rx_class == PRIM_X_RDY)
               next_state = S_RCV_WAIT_FIFO;
         S_SEND_CHK_RDY:
            if (rx_class == PRIM_R_RDY && fifo_start_ok)
               next_state = S_SEND_SOF;
            else if (rx_class == PRIM_X_RDY)
               next_state = S_RPT_COLLIDE;     // Device won, become receiver
         S_SEND_SOF:
            if (rx_class == PRIM_SYNC)
               next_state = S_RPT_TX_SYNC;
            else if (fifo_start_ok && tx_pop)
               next_state = S_SEND_DATA;
         S_SEND_DATA:
            if (fifo_data_ok && rx_class == PRIM_HOLD)
               next_state = S_SEND_HOLD_ACK;
            else if (rx_class == PRIM_SYNC)
               next_state = S_RPT_TX_SYNC;
            else if (is_prim && fifo_end_ok && !fifo_data_ok)
               next_state = S_SEND_CRC;        // Last word at the head
            else if (is_prim && !fifo_end_ok)
               next_state = S_SEND_HOLD;       // FIFO ran dry
            else if (tx_abort)
               next_state = S_SYNC_ESCAPE;
         S_SEND_HOLD_ACK:
            if (fifo_end_ok && is_prim && rx_class != PRIM_HOLD &&
                rx_class != PRIM_SYNC)
               next_state = S_SEND_DATA;
            else if (rx_class == PRIM_SYNC)
               next_state = S_RPT_TX_SYNC;
            else if (tx_abort)
               next_state = S_SYNC_ESCAPE;
         S_SEND_HOLD:
            if (fifo_end_ok && is_prim && rx_class != PRIM_HOLD &&
                rx_class != PRIM_SYNC && tx_pop)
               next_state = S_SEND_DATA;
            else if (rx_class == PRIM_HOLD)
               next_state = S_SEND_HOLD_ACK;
            else if (rx_class == PRIM_SYNC)
               next_state = S_RPT_TX_SYNC;
            else if (tx_abort)
               next_state = S_SYNC_ESCAPE;
         S_SEND_CRC:
            if (rx_class == PRIM_SYNC)
               next_state = S_RPT_TX_SYNC;
            else if (is_prim && tx_pop)
               next_state = S_SEND_EOF;
         S_SEND_EOF:
            if (rx_class == PRIM_SYNC)
               next_state = S_RPT_TX_SYNC;
            else if (is_prim && tx_pop)
               next_state = S_SEND_WAIT;
         S_SEND_WAIT:
            if (rx_class == PRIM_R_OK)
               next_state = S_RPT_R_OK;
            else if (rx_class == PRIM_R_ERR)
               next_state = S_RPT_R_ERR;
            else if (rx_class == PRIM_SYNC)
               next_state = S_RPT_TX_SYNC;
         S_SYNC_ESCAPE:
            if (rx_class == PRIM_SYNC || rx_class == PRIM_X_RDY)
               next_state = S_IDLE;
         S_RCV_WAIT_FIFO:
            if (rx_class == PRIM_X_RDY && rcv_ready)
               next_state = S_RCV_CHK_RDY;
            else if (is_prim && rx_class != PRIM_X_RDY)
               next_state = S_IDLE;
         S_RCV_CHK_RDY:
            if (rx_class == PRIM_SOF)
               next_state = S_RCV_DATA;
            else if (is_prim && rx_class != PRIM_X_RDY)
               next_state = S_IDLE;
         S_RCV_DATA:
            if (rx_class == PRIM_HOLDA)
               next_state = S_RCV_DATA;
            else if (rx_class == PRIM_EOF)
               next_state = S_RCV_EOF;
            else if (!rcv_ready)
               next_state = S_RCV_HOLD_TX;     // Receive FIFO full
            else if (rx_class == PRIM_HOLD)
               next_state = S_RCV_HOLD_ACK;
            else if (rx_class == PRIM_WTRM)
               next_state = S_BAD_END;
            else if (rx_class == PRIM_SYNC)
               next_state = S_RPT_RX_SYNC;
            else if (rcv_abort)
               next_state = S_RPT_ABORT;
         S_RCV_HOLD_TX:
            if (rcv_ready && rx_class == PRIM_HOLD)
               next_state = S_RCV_HOLD_ACK;
            else if (rx_class == PRIM_EOF)
               next_state = S_RCV_EOF;
            else if (rx_class == PRIM_SYNC)
               next_state = S_RPT_RX_SYNC;
            else if (rcv_abort)
               next_state = S_RPT_ABORT;
            else if (rcv_ready)
               next_state = S_RCV_DATA;
         S_RCV_HOLD_ACK:
            if (rx_class == PRIM_HOLD)
               next_state = S_RCV_HOLD_ACK;
            else if (rx_class == PRIM_EOF)
               next_state = S_RCV_EOF;
            else if (rx_class == PRIM_SYNC)
               next_state = S_RPT_RX_SYNC;
            else if (rcv_abort)
               next_state = S_RPT_ABORT;
            else
               next_state = S_RCV_DATA;        // Device resumed data
         S_RCV_EOF:
            if (crc_rdy)
               next_state = crc_ok ? S_GOOD_CRC : S_BAD_END;
         S_GOOD_CRC:
            next_state = (rx_class == PRIM_SYNC) ? S_RPT_RX_SYNC : S_GOOD_END;
         S_GOOD_END:
            if (rx_class == PRIM_SYNC)
               next_state = S_RPT_GOOD;
         S_BAD_END:
            if (rx_class == PRIM_SYNC)
               next_state = S_RPT_BAD;
         S_RPT_COLLIDE:
            if (cmpl_ready)
               next_state = S_RCV_WAIT_FIFO;
         S_RPT_TX_SYNC, S_RPT_R_OK, S_RPT_R_ERR, S_RPT_RX_SYNC,
         S_RPT_GOOD, S_RPT_BAD, S_RPT_ABORT:
            if (cmpl_ready)
               next_state = S_IDLE;
         default:
            next_state = S_IDLE;
      endcase
      if (!link_up)
         next_state = S_IDLE;                  // Link lost, drop everything
   end

   assign rx_sof    = (state == S_RCV_CHK_RDY) && (rx_class == PRIM_SOF);
   assign rx_eof    = rcv_body && (rx_class == PRIM_EOF);
   assign rx_datav  = rcv_body && (rx_class == PRIM_DATA);
   assign link_idle = (state == S_IDLE);

endmodule

`default_nettype wire

/* prim_encoder.sv */
// Primitive encoder: registers the outgoing primitive or data marker for the next link state
`timescale 1ns/1ps
`default_nettype none

module prim_encoder (
   input  wire                            clk_75m,
   input  wire                            arst_n,
   input  var sata_link_pkg::link_state_t next_state,
   output sata_link_pkg::prim_word_t      tx_char,
   output logic                           tx_chark
);

   import sata_link_pkg::*;

   always_ff @(posedge clk_75m or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tx_char  <= P_SYNC;
         tx_chark <= 1'b1;
      end
      else
      begin
         tx_chark <= 1'b1;
         case (next_state)
            S_SEND_CHK_RDY:  tx_char <= P_X_RDY;
            S_SEND_SOF:      tx_char <= P_SOF;
            S_SEND_DATA, S_SEND_CRC:
            begin
               tx_char  <= '0;                 // Datapath substitutes payload
               tx_chark <= 1'b0;
            end
            S_SEND_EOF:      tx_char <= P_EOF;
            S_SEND_WAIT:     tx_char <= P_WTRM;
            S_SEND_HOLD:     tx_char <= P_HOLD;
            S_SEND_HOLD_ACK: tx_char <= P_HOLDA;
            S_RCV_CHK_RDY:   tx_char <= P_R_RDY;
            S_RCV_DATA, S_RCV_EOF, S_GOOD_CRC:
               tx_char <= P_R_IP;
            S_RCV_HOLD_TX:   tx_char <= P_HOLD;
            S_RCV_HOLD_ACK:  tx_char <= P_HOLDA;
            S_GOOD_END:      tx_char <= P_R_OK;
            S_BAD_END:       tx_char <= P_R_ERR;
            default:         tx_char <= P_SYNC;  // Idle, escape, waits and reports
         endcase
      end
   end

endmodule

`default_nettype wire

/* completion_reporter.sv */
// Completion reporter: completion word, transmit FIFO reset and discard level from the next state
`timescale 1ns/1ps
`default_nettype none

module completion_reporter (
   input  wire                            clk_75m,
   input  wire                            arst_n,
   input  var sata_link_pkg::link_state_t next_state,
   input  wire                            link_up,
   output logic                           cmpl_valid,
   output sata_link_pkg::cmpl_code_t      cmpl_code,
   output logic                           tx_fifo_rst,
   output logic                           tx_discard
);

   import sata_link_pkg::*;

   logic is_rpt;
   logic is_rcv;

   assign is_rpt = next_state inside {S_RPT_COLLIDE, S_RPT_TX_SYNC, S_RPT_R_OK,
                                      S_RPT_R_ERR, S_RPT_RX_SYNC, S_RPT_GOOD,
                                      S_RPT_BAD, S_RPT_ABORT};

   // Whole receive path, including its reports
   assign is_rcv = next_state inside {S_RCV_WAIT_FIFO, S_RCV_CHK_RDY, S_RCV_DATA,
                                      S_RCV_HOLD_TX, S_RCV_HOLD_ACK, S_RCV_EOF,
                                      S_GOOD_CRC, S_GOOD_END, S_BAD_END,
                                      S_RPT_RX_SYNC, S_RPT_GOOD, S_RPT_BAD,
                                      S_RPT_ABORT};

   always_ff @(posedge clk_75m or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cmpl_valid  <= 1'b0;
         tx_fifo_rst <= 1'b1;
         tx_discard  <= 1'b0;
      end
      else
      begin
         cmpl_valid  <= is_rpt;
         tx_fifo_rst <= is_rpt | ~link_up;     // Flush after every transfer
         tx_discard  <= is_rcv;
      end
   end

   always_ff @(posedge clk_75m)
   begin
      case (next_state)
         S_RPT_COLLIDE: cmpl_code <= CMPL_COLLIDE;
         S_RPT_TX_SYNC: cmpl_code <= CMPL_TX_SYNC;
         S_RPT_R_OK:    cmpl_code <= CMPL_R_OK;
         S_RPT_R_ERR:   cmpl_code <= CMPL_R_ERR;
         S_RPT_RX_SYNC: cmpl_code <= CMPL_RX_SYNC;
         S_RPT_GOOD:    cmpl_code <= CMPL_GOOD;
         S_RPT_BAD:     cmpl_code <= CMPL_BAD;
         S_RPT_ABORT:   cmpl_code <= CMPL_ABORT;
         default:       cmpl_code <= cmpl_code;  // Held outside reports
      endcase
   end

endmodule

`default_nettype wire

/* sata_link.sv */
// SATA host link layer control: decoder, sequencer, primitive encoder and completion reporter
`timescale 1ns/1ps
`default_nettype none

module sata_link (
   input  wire                           clk_75m,
   input  wire                           arst_n,
   input  wire                           link_up,
   input  var sata_link_pkg::prim_word_t rx_char,
   input  wire                           rx_chark,
   input  wire                           tx_pop,
   input  wire                           crc_ok,
   input  wire                           crc_rdy,
   input  wire                           fifo_sof,
   input  wire                           fifo_eof,
   input  wire                           fifo_empty,
   input  wire                           fifo_almost_empty,
   input  wire                           tx_abort,
   input  wire                           rcv_ready,
   input  wire                           rcv_abort,
   input  wire                           cmpl_ready,
   output sata_link_pkg::prim_word_t     tx_char,
   output logic                          tx_chark,
   output logic                          rx_sof,
   output logic                          rx_eof,
   output logic                          rx_datav,
   output logic                          cmpl_valid,
   output sata_link_pkg::cmpl_code_t     cmpl_code,
   output logic                          tx_fifo_rst,
   output logic                          tx_discard,
   output logic                          link_idle
);

   import sata_link_pkg::*;

   prim_class_t rx_class;
   link_state_t next_state;
   logic        fifo_data_ok;
   logic        fifo_end_ok;
   logic        fifo_start_ok;

   prim_decoder u_prim_decoder (
      .rx_char           (rx_char),
      .rx_chark          (rx_chark),
      .fifo_sof          (fifo_sof),
      .fifo_eof          (fifo_eof),
      .fifo_empty        (fifo_empty),
      .fifo_almost_empty (fifo_almost_empty),
      .rx_class          (rx_class),
      .fifo_data_ok      (fifo_data_ok),
      .fifo_end_ok       (fifo_end_ok),
      .fifo_start_ok     (fifo_start_ok)
   );

   link_sequencer u_link_sequencer (
      .clk_75m       (clk_75m),
      .arst_n        (arst_n),
      .link_up       (link_up),
      .rx_class      (rx_class),
      .fifo_data_ok  (fifo_data_ok),
      .fifo_end_ok   (fifo_end_ok),
      .fifo_start_ok (fifo_start_ok),
      .tx_pop        (tx_pop),
      .crc_ok        (crc_ok),
      .crc_rdy       (crc_rdy),
      .tx_abort      (tx_abort),
      .rcv_ready     (rcv_ready),
      .rcv_abort     (rcv_abort),
      .cmpl_ready    (cmpl_ready),
      .next_state    (next_state),
      .rx_sof        (rx_sof),
      .rx_eof        (rx_eof),
      .rx_datav      (rx_datav),
      .link_idle     (link_idle)
   );

   prim_encoder u_prim_encoder (
      .clk_75m    (clk_75m),
      .arst_n     (arst_n),
      .next_state (next_state),
      .tx_char    (tx_char),
      .tx_chark   (tx_chark)
   );

   completion_reporter u_completion_reporter (
      .clk_75m     (clk_75m),
      .arst_n      (arst_n),
      .next_state  (next_state),
      .link_up     (link_up),
      .cmpl_valid  (cmpl_valid),
      .cmpl_code   (cmpl_code),
      .tx_fifo_rst (tx_fifo_rst),
      .tx_discard  (tx_discard)
   );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Testbench clock and reset source: 4 ns clock, reset held low for the first 8 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_75m,
   output logic arst_n
);

   localparam realtime HALF_PERIOD  = 2.0;
   localparam int      RESET_CYCLES = 8;

   initial
   begin
      clk_75m = 1'b0;
      forever
         #(HALF_PERIOD) clk_75m = ~clk_75m;
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES)
         @(posedge clk_75m);
      @(negedge clk_75m);
      arst_n = 1'b1;                           // Release away from the active edge
   end

endmodule

`default_nettype wire

/* tb_sata_link.sv */
// Testbench for the SATA host link layer with device model, random frames and completion checks
`timescale 1ns/1ps
`default_nettype none

module tb_sata_link;

   import sata_link_pkg::*;

   localparam int NUM_FRAMES = 13;
   localparam int MODE_END   = 0;             // Frame runs to R_OK or R_ERR
   localparam int MODE_SYNC  = 1;             // Device escapes with SYNC
   localparam int MODE_LINK  = 2;             // Link drops mid-frame

   logic        clk_75m, arst_n;
   logic        link_up, rx_chark, tx_pop, crc_ok, crc_rdy;
   logic        fifo_sof, fifo_eof, fifo_empty, fifo_almost_empty;
   logic        tx_abort, rcv_ready, rcv_abort, cmpl_ready;
   prim_word_t  rx_char, tx_char;
   logic        tx_chark, rx_sof, rx_eof, rx_datav;
   logic        cmpl_valid, tx_fifo_rst, tx_discard, link_idle;
   cmpl_code_t  cmpl_code;

   int          frame_len [NUM_FRAMES];
   int          cycle_cnt, cycle_limit, word_sum, i;
   int          check_cnt, error_cnt, test_cnt, err_start;
   int          sof_cnt, eof_cnt, data_cnt, sof_start, eof_start, data_start;
   string       test_name;

   tb_clock_gen clock_gen (.clk_75m, .arst_n);

   sata_link DUT (.*);

   // Count receive strobes on the edge that takes the dword
   always @(posedge clk_75m)
   begin
      if (rx_sof)
         sof_cnt++;
      if (rx_eof)
         eof_cnt++;
      if (rx_datav)
         data_cnt++;
   end

   initial
   begin
      @(posedge arst_n);
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge clk_75m);
         cycle_cnt++;
      end
      $display("Timeout: the DUT did not finish the tests within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
   end

   task automatic send(input prim_word_t word, input logic k);
      rx_char  = word;
      rx_chark = k;
   endtask

   // Head status of a FIFO holding the rest of one frame
   task automatic set_fifo(input int remain, input logic first);
      fifo_empty        = (remain == 0);
      fifo_almost_empty = (remain == 1);
      fifo_sof          = first && (remain > 0);
      fifo_eof          = (remain == 1);
   endtask

   task automatic wait_tx(input prim_word_t word);
      while (tx_char !== word)
         @(negedge clk_75m);
   endtask

   task automatic check_prim(input prim_word_t exp_char, input logic exp_k);
      check_cnt++;
      if (tx_char !== exp_char || tx_chark !== exp_k)
      begin
         error_cnt++;
         $display("** Error %s: expected %h k=%b, actual %h k=%b",
                  test_name, exp_char, exp_k, tx_char, tx_chark);
      end
   endtask

   task automatic check_cmpl(input cmpl_code_t exp_code);
      check_cnt++;
      if (cmpl_code !== exp_code)
      begin
         error_cnt++;
         $display("** Error %s: expected %s, actual %s",
                  test_name, exp_code.name(), cmpl_code.name());
      end
   endtask

   task automatic check_count(input string what, input int exp_cnt, input int act_cnt);
      check_cnt++;
      if (act_cnt != exp_cnt)
      begin
         error_cnt++;
         $display("** Error %s: %s expected %0d, actual %0d", test_name, what, exp_cnt, act_cnt);
      end
   endtask

   task automatic check_level(input string what, input logic exp_lvl, input logic act_lvl);
      check_cnt++;
      if (act_lvl !== exp_lvl)
      begin
         error_cnt++;
         $display("** Error %s: %s expected %b, actual %b", test_name, what, exp_lvl, act_lvl);
      end
   endtask

   task automatic begin_test(input string name);
      test_name  = name;
      err_start  = error_cnt;
      sof_start  = sof_cnt;
      eof_start  = eof_cnt;
      data_start = data_cnt;
   endtask

   task automatic end_test();
      test_cnt++;
      $display("%-14s %s", test_name, (error_cnt == err_start) ? "ok" : "FAIL");
   endtask

   // Command layer stalls a random time and then takes the word
   task automatic take_completion(input cmpl_code_t exp_code, input logic to_idle);
      int delay;
      delay = $urandom_range(0, 5);
      while (cmpl_valid !== 1'b1)
         @(negedge clk_75m);
      repeat (delay + 1)
      begin
         check_cmpl(exp_code);
         check_prim(P_SYNC, 1'b1);
         check_level("tx_fifo_rst", 1'b1, tx_fifo_rst);
         @(negedge clk_75m);
      end
      set_fifo(0, 1'b0);                       // FIFO flushed by tx_fifo_rst
      check_level("cmpl_valid", 1'b1, cmpl_valid);
      cmpl_ready = 1'b1;
      @(negedge clk_75m);
      cmpl_ready = 1'b0;
      check_level("cmpl_valid", 1'b0, cmpl_valid);
      if (to_idle)
         check_level("link_idle", 1'b1, link_idle);
   endtask

   task automatic transmit_frame(input int n, input int mode, input int at);
      int   k;
      logic good;
      good   = ($urandom_range(0, 1) == 1);
      tx_pop = 1'b1;
      set_fifo(n, 1'b1);
      send(P_SYNC, 1'b1);
      wait_tx(P_X_RDY);
      send(P_R_RDY, 1'b1);
      @(negedge clk_75m);
      check_prim(P_SOF, 1'b1);
      send(P_R_IP, 1'b1);
      @(negedge clk_75m);
      for (k = 0; k <= n; k++)
      begin
         check_prim('0, 1'b0);                 // Payload words and then CRC
         set_fifo(n - k, k == 0);
         if (k == at)
            break;
         @(negedge clk_75m);
      end
      if (mode == MODE_SYNC)
      begin
         send(P_SYNC, 1'b1);
         @(negedge clk_75m);
         take_completion(CMPL_TX_SYNC, 1'b1);
      end
      else if (mode == MODE_LINK)
      begin
         link_up = 1'b0;
         @(negedge clk_75m);
         check_prim(P_SYNC, 1'b1);
         check_level("link_idle", 1'b1, link_idle);
         check_level("tx_fifo_rst", 1'b1, tx_fifo_rst);
         link_up = 1'b1;
         set_fifo(0, 1'b0);
         send(P_SYNC, 1'b1);
         @(negedge clk_75m);
      end
      else
      begin
         check_prim(P_EOF, 1'b1);
         @(negedge clk_75m);
         check_prim(P_WTRM, 1'b1);
         send(good ? P_R_OK : P_R_ERR, 1'b1);
         @(negedge clk_75m);
         send(P_SYNC, 1'b1);
         take_completion(good ? CMPL_R_OK : CMPL_R_ERR, 1'b1);
      end
      tx_pop = 1'b0;
   endtask

   task automatic receive_frame(input int n, input int hold_at);
      int   k;
      logic good;
      good = ($urandom_range(0, 1) == 1);
      send(P_X_RDY, 1'b1);
      wait_tx(P_R_RDY);
      check_level("tx_discard", 1'b1, tx_discard);
      send(P_SOF, 1'b1);
      @(negedge clk_75m);
      check_prim(P_R_IP, 1'b1);
      for (k = 0; k < n; k++)
      begin
         if (k == hold_at)
         begin
            send(P_HOLD, 1'b1);                // Device pauses mid-frame
            @(negedge clk_75m);
            repeat ($urandom_range(1, 4))
            begin
               check_prim(P_HOLDA, 1'b1);
               @(negedge clk_75m);
            end
         end
         send($urandom, 1'b0);
         @(negedge clk_75m);
      end
      send(P_EOF, 1'b1);
      @(negedge clk_75m);
      crc_rdy = 1'b1;
      crc_ok  = good;
      send(P_WTRM, 1'b1);
      while (tx_char === P_R_IP)
         @(negedge clk_75m);
      check_prim(good ? P_R_OK : P_R_ERR, 1'b1);
      crc_rdy = 1'b0;
      send(P_SYNC, 1'b1);
      take_completion(good ? CMPL_GOOD : CMPL_BAD, 1'b1);
      check_count("rx_sof", 1, sof_cnt - sof_start);
      check_count("rx_datav", n, data_cnt - data_start);
      check_count("rx_eof", 1, eof_cnt - eof_start);
   endtask

   task automatic collide_then_receive(input int n);
      set_fifo(n, 1'b1);
      send(P_SYNC, 1'b1);
      wait_tx(P_X_RDY);
      send(P_X_RDY, 1'b1);                     // Device wants the bus too
      @(negedge clk_75m);
      take_completion(CMPL_COLLIDE, 1'b0);
      receive_frame(n, -1);
   endtask

   initial
   begin
      void'($urandom(32'h889f));
      link_up    = 1'b1;
      tx_pop     = 1'b0;
      crc_ok     = 1'b0;
      crc_rdy    = 1'b0;
      tx_abort   = 1'b0;
      rcv_ready  = 1'b1;
      rcv_abort  = 1'b0;
      cmpl_ready = 1'b0;
      send(P_SYNC, 1'b1);
      set_fifo(0, 1'b0);
      word_sum = 0;
      for (i = 0; i < NUM_FRAMES; i++)
      begin
         frame_len[i] = (i >= 8) ? $urandom_range(2, 16) : $urandom_range(1, 16);
         word_sum += frame_len[i];
      end
      cycle_limit = 64 * word_sum + 2000;

      @(posedge arst_n);
      @(negedge clk_75m);
      begin_test("reset");
      check_prim(P_SYNC, 1'b1);
      check_level("cmpl_valid", 1'b0, cmpl_valid);
      check_level("link_idle", 1'b1, link_idle);
      end_test();

      for (i = 0; i < 4; i++)
      begin
         begin_test("transmit");
         transmit_frame(frame_len[i], MODE_END, -1);
         end_test();
      end
      for (i = 4; i < 8; i++)
      begin
         begin_test("receive");
         receive_frame(frame_len[i], -1);
         end_test();
      end
      for (i = 8; i < 10; i++)
      begin
         begin_test("receive hold");
         receive_frame(frame_len[i], $urandom_range(1, frame_len[i] - 1));
         end_test();
      end
      begin_test("collision");
      collide_then_receive(frame_len[10]);
      end_test();
      begin_test("sync abort");
      transmit_frame(frame_len[11], MODE_SYNC, $urandom_range(0, frame_len[11] - 1));
      end_test();
      begin_test("link down");
      transmit_frame(frame_len[12], MODE_LINK, $urandom_range(0, frame_len[12] - 1));
      end_test();

      $display("Tests: %0d  checks: %0d  errors: %0d", test_cnt, check_cnt, error_cnt);
      if (error_cnt == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
sata_link_pkg.sv
prim_decoder.sv
link_sequencer.sv
prim_encoder.sv
completion_reporter.sv
sata_link.sv
tb_clock_gen.sv
tb_sata_link.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_sata_link
FILELIST  := all.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
